// ==== prog.hex ====
// one 64-bit word per entry, 4 words per line, word index 0 to 63
// word i = {i, 11, i, 22, ~i, 33, ~i, 44}
00110022ff33ff44 01110122fe33fe44 02110222fd33fd44 03110322fc33fc44
04110422fb33fb44 05110522fa33fa44 06110622f933f944 07110722f833f844
08110822f733f744 09110922f633f644 0a110a22f533f544 0b110b22f433f444
0c110c22f333f344 0d110d22f233f244 0e110e22f133f144 0f110f22f033f044
10111022ef33ef44 11111122ee33ee44 12111222ed33ed44 13111322ec33ec44
14111422eb33eb44 15111522ea33ea44 16111622e933e944 17111722e833e844
18111822e733e744 19111922e633e644 1a111a22e533e544 1b111b22e433e444
1c111c22e333e344 1d111d22e233e244 1e111e22e133e144 1f111f22e033e044
20112022df33df44 21112122de33de44 22112222dd33dd44 23112322dc33dc44
24112422db33db44 25112522da33da44 26112622d933d944 27112722d833d844
28112822d733d744 29112922d633d644 2a112a22d533d544 2b112b22d433d444
2c112c22d333d344 2d112d22d233d244 2e112e22d133d144 2f112f22d033d044
30113022cf33cf44 31113122ce33ce44 32113222cd33cd44 33113322cc33cc44
34113422cb33cb44 35113522ca33ca44 36113622c933c944 37113722c833c844
38113822c733c744 39113922c633c644 3a113a22c533c544 3b113b22c433c444
3c113c22c333c344 3d113d22c233c244 3e113e22c133c144 3f113f22c033c044

// ==== files.f ====
common/fetch_pkg.sv
design/pc_gen.sv
design/rd_arbiter.sv
axi_rd/rd_latency_timer.sv
axi_rd/axi_rd_master.sv
axi_rd/axi_rd_slave.sv
design/fetch_stage.sv
tb/fetch_stage_assertions.sv
tb/fetch_stage_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := fetch_stage_tb
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --assert --timing -Wno-fatal
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Simulation PASSED
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/fetch_stage_tb.sv ====
`default_nettype none

module fetch_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // cycles allowed per awaited event
  localparam int WAIT_LIMIT = 100;

  logic             clk;
  logic             rst_n;
  logic             stall_i;
  logic             redirect_i;
  fetch_pkg::addr_t redirect_pc_i;
  logic             mem_valid_i;
  fetch_pkg::rid_t  mem_id_i;
  fetch_pkg::addr_t mem_addr_i;
  fetch_pkg::inst_t inst_o;
  logic             inst_valid_o;
  fetch_pkg::addr_t pc_o;
  logic             mem_done_o;
  fetch_pkg::data_t mem_rdata_o;

  int tests_run;
  int tests_bad;
  int fails_at_start;
  bit test_ok;

  fetch_stage dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_valid_i   (mem_valid_i),
    .mem_id_i      (mem_id_i),
    .mem_addr_i    (mem_addr_i),
    .inst_o        (inst_o),
    .inst_valid_o  (inst_valid_o),
    .pc_o          (pc_o),
    .mem_done_o    (mem_done_o),
    .mem_rdata_o   (mem_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // outputs sampled on the falling edge, away from the drive edge
  task automatic count_fetches(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (inst_valid_o) begin
        seen++;
        cycles = 0;
      end
    end
    if (seen < n) begin
      test_ok = 1'b0;
    end
  endtask

  // memory-stage request held until its done pulse
  task automatic mem_read(input fetch_pkg::addr_t addr, input fetch_pkg::rid_t id);
    int cycles;
    cycles = 0;
    @(posedge clk);
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_id_i    <= id;
    @(negedge clk);
    while (!mem_done_o && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_done_o) begin
      test_ok = 1'b0;
    end
    @(posedge clk);
    mem_valid_i <= 1'b0;
  endtask

  task automatic start_test();
    test_ok        = 1'b1;
    fails_at_start = dut_i.u_checker.fail_cnt;
  endtask

  task automatic close_test(input string name);
    int fails;
    // let the last assertion edges settle
    repeat (2) @(negedge clk);
    fails = dut_i.u_checker.fail_cnt - fails_at_start;
    tests_run++;
    if (fails != 0) begin
      tests_bad++;
      $display("Mismatch at %0t: %s, %0d assertion failures", $time, name, fails);
    end else if (!test_ok) begin
      tests_bad++;
      $display("[%0t] %s: gave up, the DUT did not respond in time", $time, name);
    end else begin
      $display("[%0t] %s: ok", $time, name);
    end
  endtask

  initial begin
    void'($urandom(8056));
    $timeformat(-9, 0, " ns", 0);
    rst_n         = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    mem_valid_i   = 1'b0;
    mem_id_i      = 4'd1;
    mem_addr_i    = '0;
    tests_run     = 0;
    tests_bad     = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    start_test();
    count_fetches(1);
    close_test("reset and first fetch");

    start_test();
    count_fetches(8);
    close_test("sequential fetch");

    // random point, often with a fetch in flight
    start_test();
    repeat (6) begin
      repeat (1 + $urandom % 6) @(posedge clk);
      redirect_i    <= 1'b1;
      redirect_pc_i <= fetch_pkg::addr_t'(($urandom % (2 * fetch_pkg::MEM_WORDS)) * 4);
      @(posedge clk);
      redirect_i <= 1'b0;
      count_fetches(2);
    end
    close_test("redirect");

    start_test();
    repeat (4) begin
      repeat (1 + $urandom % 4) @(posedge clk);
      stall_i <= 1'b1;
      repeat (3 + $urandom % 12) @(posedge clk);
      stall_i <= 1'b0;
      count_fetches(2);
    end
    close_test("stall");

    // addresses beyond the array exercise the wrap
    start_test();
    repeat (6) begin
      mem_read(fetch_pkg::addr_t'(($urandom % (4 * fetch_pkg::MEM_WORDS)) * 8),
               fetch_pkg::rid_t'(1 + $urandom % 15));
    end
    count_fetches(2);
    close_test("memory-stage read");

    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_run, tests_bad, dut_i.u_checker.fail_cnt);
    if (tests_bad == 0 && dut_i.u_checker.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/fetch_stage_assertions.sv ====
`default_nettype none

module fetch_stage_checker (
  input wire                   clk,
  input wire                   rst_n,
  input wire                   stall_i,
  input wire                   redirect_i,
  input wire fetch_pkg::addr_t redirect_pc_i,
  input wire                   mem_valid_i,
  input wire fetch_pkg::addr_t mem_addr_i,
  input wire fetch_pkg::inst_t inst_i,
  input wire                   inst_valid_i,
  input wire fetch_pkg::addr_t pc_i,
  input wire                   mem_done_i,
  input wire fetch_pkg::data_t mem_rdata_i,
  input wire                   fetch_done_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // reference copy of the program image
  fetch_pkg::data_t mem_words [fetch_pkg::MEM_WORDS];
  int               fail_cnt = 0;

  // next valid must land on this target
  logic             redir_pend_q;
  fetch_pkg::addr_t redir_tgt_q;
  // previous valid is a sequential predecessor
  logic             seq_q;
  fetch_pkg::addr_t last_pc_q;
  logic             stall_seen_q;
  // current mem request already answered
  logic             mem_done_seen_q;
  // some fetch has completed since reset
  logic             fetched_q;

  initial begin
    $readmemh("prog.hex", mem_words);
  end

  // upper address bits wrap
  function automatic fetch_pkg::data_t word_at(input fetch_pkg::addr_t a);
    return mem_words[a[fetch_pkg::WORD_LSB +: fetch_pkg::WORD_IDX_W]];
  endfunction

  function automatic fetch_pkg::inst_t inst_at(input fetch_pkg::addr_t a);
    fetch_pkg::data_t w;
    w = word_at(a);
    return a[2] ? w[63:32] : w[31:0];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // first fetch out of reset behaves like a jump to the reset pc
      redir_pend_q    <= 1'b1;
      redir_tgt_q     <= fetch_pkg::RESET_PC;
      seq_q           <= 1'b0;
      last_pc_q       <= '0;
      stall_seen_q    <= 1'b0;
      mem_done_seen_q <= 1'b0;
      fetched_q       <= 1'b0;
    end else begin
      if (redirect_i) begin
        redir_pend_q <= 1'b1;
        redir_tgt_q  <= redirect_pc_i;
      end else if (inst_valid_i) begin
        redir_pend_q <= 1'b0;
      end
      if (inst_valid_i) begin
        last_pc_q <= pc_i;
      end
      if (redirect_i || stall_i) begin
        seq_q <= 1'b0;
      end else if (inst_valid_i) begin
        seq_q <= 1'b1;
      end
      if (!stall_i) begin
        stall_seen_q <= 1'b0;
      end else if (inst_valid_i) begin
        stall_seen_q <= 1'b1;
      end
      if (mem_done_i) begin
        mem_done_seen_q <= 1'b1;
      end else if (!mem_valid_i) begin
        mem_done_seen_q <= 1'b0;
      end
      if (fetch_done_i) begin
        fetched_q <= 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !fetched_q |-> !inst_valid_i && !mem_done_i && inst_i == fetch_pkg::NOP_INST)
    else begin fail_cnt++; $error("output activity before the first fetch"); end

  a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_i |-> inst_i == fetch_pkg::NOP_INST)
    else begin fail_cnt++; $error("inst_o is not NOP while idle"); end

  a_valid_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i |-> $past(fetch_done_i))
    else begin fail_cnt++; $error("inst_valid_o without a completed fetch"); end

  a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i |-> inst_i == inst_at(pc_i))
    else begin fail_cnt++; $error("inst_o %h wrong for pc %h", inst_i, pc_i); end

  a_sequential: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && seq_q |-> pc_i == last_pc_q + 64'd4)
    else begin fail_cnt++; $error("pc %h does not follow %h", pc_i, last_pc_q); end

  a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && redir_pend_q |-> pc_i == redir_tgt_q)
    else begin fail_cnt++; $error("pc %h, expected target %h", pc_i, redir_tgt_q); end

  a_stall_once: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i && inst_valid_i |-> !stall_seen_q)
    else begin fail_cnt++; $error("second fetch returned under stall"); end

  a_stall_pc: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i && stall_seen_q |-> pc_i == last_pc_q)
    else begin fail_cnt++; $error("pc_o moved under stall"); end

  a_mem_once: assert property (@(posedge clk) disable iff (!rst_n)
    mem_done_i |-> mem_valid_i && !mem_done_seen_q && !inst_valid_i)
    else begin fail_cnt++; $error("unexpected or colliding mem_done_o"); end

  a_mem_data: assert property (@(posedge clk) disable iff (!rst_n)
    mem_done_i |-> mem_rdata_i == word_at(mem_addr_i))
    else begin fail_cnt++; $error("mem_rdata_o wrong for %h", mem_addr_i); end

endmodule

bind fetch_stage fetch_stage_checker u_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .stall_i       (stall_i),
  .redirect_i    (redirect_i),
  .redirect_pc_i (redirect_pc_i),
  .mem_valid_i   (mem_valid_i),
  .mem_addr_i    (mem_addr_i),
  .inst_i        (inst_o),
  .inst_valid_i  (inst_valid_o),
  .pc_i          (pc_o),
  .mem_done_i    (mem_done_o),
  .mem_rdata_i   (mem_rdata_o),
  .fetch_done_i  (fetch_done)
);

`default_nettype wire

// ==== design/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   stall_i,
  input  wire                   redirect_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  input  wire                   mem_valid_i,
  input  wire fetch_pkg::rid_t  mem_id_i,
  input  wire fetch_pkg::addr_t mem_addr_i,
  output fetch_pkg::inst_t      inst_o,
  output logic                  inst_valid_o,
  output fetch_pkg::addr_t      pc_o,
  output logic                  mem_done_o,
  output fetch_pkg::data_t      mem_rdata_o
);

  logic               fetch_req;
  fetch_pkg::addr_t   fetch_pc;
  logic               fetch_done;
  logic               fetch_ok;
  logic               issue;
  fetch_pkg::rd_req_t rd_req;
  logic               rd_done;
  fetch_pkg::rd_rsp_t rd_rsp;
  fetch_pkg::data_t   rd_data;

  // AR / R channel between master and slave
  logic               ar_valid;
  logic               ar_ready;
  fetch_pkg::addr_t   ar_addr;
  logic               r_valid;
  logic               r_ready;
  fetch_pkg::data_t   r_data;

  // registered fetch result
  logic               inst_valid_q;
  fetch_pkg::data_t   word_q;
  fetch_pkg::addr_t   pc_q;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_done_i  (fetch_done),
    .fetch_req_o   (fetch_req),
    .fetch_pc_o    (fetch_pc),
    .fetch_ok_o    (fetch_ok)
  );

  rd_arbiter u_rd_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req),
    .fetch_pc_i   (fetch_pc),
    .mem_valid_i  (mem_valid_i),
    .mem_id_i     (mem_id_i),
    .mem_addr_i   (mem_addr_i),
    .rd_done_i    (rd_done),
    .rd_rsp_i     (rd_rsp),
    .issue_o      (issue),
    .req_o        (rd_req),
    .fetch_done_o (fetch_done),
    .mem_done_o   (mem_done_o),
    .rd_data_o    (rd_data)
  );

  axi_rd_master u_axi_rd_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue_i    (issue),
    .req_i      (rd_req),
    .ar_ready_i (ar_ready),
    .r_valid_i  (r_valid),
    .r_data_i   (r_data),
    .ar_valid_o (ar_valid),
    .ar_addr_o  (ar_addr),
    .r_ready_o  (r_ready),
    .rd_done_o  (rd_done),
    .rd_rsp_o   (rd_rsp)
  );

  axi_rd_slave u_axi_rd_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .r_ready_i  (r_ready),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data)
  );

  // done delayed one cycle, stale fetches dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid_q <= 1'b0;
      pc_q         <= fetch_pkg::RESET_PC;
    end else begin
      inst_valid_q <= fetch_done & fetch_ok;
      if (fetch_done && fetch_ok) begin
        pc_q <= fetch_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done && fetch_ok) begin
      word_q <= rd_data;
    end
  end

  assign inst_valid_o = inst_valid_q;
  assign pc_o         = pc_q;

  // pc bit 2 picks the half-word, bubble otherwise
  assign inst_o = !inst_valid_q ? fetch_pkg::NOP_INST :
                  pc_q[2]       ? word_q[63:32] : word_q[31:0];

  // memory-stage data passes straight through on its done pulse
  assign mem_rdata_o = rd_data;

endmodule

`default_nettype wire

// ==== axi_rd/axi_rd_slave.sv ====
`default_nettype none

module axi_rd_slave (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   ar_valid_i,
  input  wire fetch_pkg::addr_t ar_addr_i,
  input  wire                   r_ready_i,
  output logic                  ar_ready_o,
  output logic                  r_valid_o,
  output fetch_pkg::data_t      r_data_o
);

  // word array, preloaded from the program image
  fetch_pkg::data_t mem_q [fetch_pkg::MEM_WORDS];

  initial begin
    $readmemh("prog.hex", mem_q);
  end

  // a read accepted and not yet returned
  logic                busy_q;
  fetch_pkg::word_idx_t idx_q;
  logic                ar_hs;
  logic                r_hs;
  logic                expired;

  // idle slave always takes an address
  assign ar_ready_o = ~busy_q;
  assign ar_hs      = ar_valid_i & ar_ready_o;
  assign r_hs       = r_valid_o & r_ready_i;

  // latency starts on the AR transfer
  rd_latency_timer u_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_i    (ar_hs),
    .expired_o (expired)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (ar_hs) begin
      busy_q <= 1'b1;
    end else if (r_hs) begin
      busy_q <= 1'b0;
    end
  end

  // upper address bits wrap around the array
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= ar_addr_i[fetch_pkg::WORD_LSB +: fetch_pkg::WORD_IDX_W];
    end
  end

  // timer stays at zero, so valid and data hold under back-pressure
  assign r_valid_o = busy_q & expired;
  assign r_data_o  = mem_q[idx_q];

endmodule

`default_nettype wire

// ==== axi_rd/axi_rd_master.sv ====
`default_nettype none

module axi_rd_master (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    issue_i,
  input  wire fetch_pkg::rd_req_t req_i,
  input  wire                    ar_ready_i,
  input  wire                    r_valid_i,
  input  wire fetch_pkg::data_t  r_data_i,
  output logic                   ar_valid_o,
  output fetch_pkg::addr_t       ar_addr_o,
  output logic                   r_ready_o,
  output logic                   rd_done_o,
  output fetch_pkg::rd_rsp_t     rd_rsp_o
);

  fetch_pkg::master_state_e state_q;
  fetch_pkg::master_state_e state_d;

  // request captured on issue, stable through AR
  fetch_pkg::addr_t addr_q;
  // tag rides along so the response can be routed
  fetch_pkg::rid_t  id_q;

  logic ar_hs;
  logic r_hs;

  assign ar_hs = ar_valid_o & ar_ready_i;
  assign r_hs  = r_ready_o & r_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE: begin
        if (issue_i) begin
          state_d = fetch_pkg::AR;
        end
      end
      fetch_pkg::AR: begin
        // wait for address accept
        if (ar_hs) begin
          state_d = fetch_pkg::R;
        end
      end
      fetch_pkg::R: begin
        // single beat, done on first data
        if (r_hs) begin
          state_d = fetch_pkg::IDLE;
        end
      end
      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == fetch_pkg::IDLE && issue_i) begin
      addr_q <= req_i.addr;
      id_q   <= req_i.id;
    end
  end

  assign ar_valid_o = (state_q == fetch_pkg::AR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state_q == fetch_pkg::R);

  // pulse in the R transfer cycle
  assign rd_done_o     = r_hs;
  assign rd_rsp_o.data = r_data_i;
  assign rd_rsp_o.id   = id_q;

endmodule

`default_nettype wire

// ==== axi_rd/rd_latency_timer.sv ====
`default_nettype none

module rd_latency_timer (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  load_i,
  output logic expired_o
);

  fetch_pkg::lat_cnt_t cnt_q;

  // counts down to zero and parks there
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= fetch_pkg::lat_cnt_t'(fetch_pkg::RD_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - fetch_pkg::lat_cnt_t'(1);
    end
  end

  // a load in flight hides a stale zero
  assign expired_o = (cnt_q == '0) & ~load_i;

endmodule

`default_nettype wire

// ==== design/rd_arbiter.sv ====
`default_nettype none

module rd_arbiter (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    fetch_req_i,
  input  wire fetch_pkg::addr_t  fetch_pc_i,
  input  wire                    mem_valid_i,
  input  wire fetch_pkg::rid_t   mem_id_i,
  input  wire fetch_pkg::addr_t  mem_addr_i,
  input  wire                    rd_done_i,
  input  wire fetch_pkg::rd_rsp_t rd_rsp_i,
  output logic                   issue_o,
  output fetch_pkg::rd_req_t     req_o,
  output logic                   fetch_done_o,
  output logic                   mem_done_o,
  output fetch_pkg::data_t       rd_data_o
);

  // one read in flight at most
  logic               busy_q;
  logic               issue_q;
  fetch_pkg::rd_req_t req_q;
  logic               grant;

  // anything pending and the bus free
  assign grant = ~busy_q & (mem_valid_i | fetch_req_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      issue_q <= 1'b0;
    end else begin
      issue_q <= grant;
      if (grant) begin
        busy_q <= 1'b1;
      end else if (rd_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // winner held until the response is back
  // memory stage has priority over fetch
  always_ff @(posedge clk) begin
    if (grant) begin
      if (mem_valid_i) begin
        req_q.addr <= mem_addr_i;
        req_q.id   <= mem_id_i;
      end else begin
        req_q.addr <= fetch_pc_i;
        req_q.id   <= fetch_pkg::IF_ID;
      end
    end
  end

  assign issue_o = issue_q;
  assign req_o   = req_q;

  // route response back by its tag
  assign fetch_done_o = rd_done_i & (rd_rsp_i.id == fetch_pkg::IF_ID);
  assign mem_done_o   = rd_done_i & (rd_rsp_i.id != fetch_pkg::IF_ID);
  assign rd_data_o    = rd_rsp_i.data;

endmodule

`default_nettype wire

// ==== design/pc_gen.sv ====
`default_nettype none

module pc_gen (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  stall_i,
  input  wire                  redirect_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  input  wire                  fetch_done_i,
  output logic                 fetch_req_o,
  output fetch_pkg::addr_t     fetch_pc_o,
  output logic                 fetch_ok_o
);

  fetch_pkg::addr_t pc_q;
  // fetch raised and not yet returned
  logic outstanding_q;
  // a redirect landed while the fetch was in flight
  logic stale_q;

  // once raised, the request stays up until its data is back
  // no new request on stall or in the redirect cycle itself
  assign fetch_req_o = outstanding_q | (~stall_i & ~redirect_i);
  assign fetch_pc_o  = pc_q;

  // a redirect in the done cycle also kills that fetch
  assign fetch_ok_o = fetch_done_i & ~stale_q & ~redirect_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= fetch_pkg::RESET_PC;
      outstanding_q <= 1'b0;
      stale_q       <= 1'b0;
    end else begin
      // redirect target wins over sequential advance
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (fetch_done_i && !stale_q) begin
        pc_q <= pc_q + 64'd4;
      end
      // stale completion leaves pc on the redirect target

      if (fetch_done_i) begin
        outstanding_q <= 1'b0;
      end else if (fetch_req_o) begin
        outstanding_q <= 1'b1;
      end

      if (fetch_done_i) begin
        stale_q <= 1'b0;
      end else if (redirect_i && outstanding_q) begin
        stale_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // base widths
  localparam int ADDR_W = 64;
  localparam int INST_W = 32;
  localparam int DATA_W = 64;
  localparam int RID_W  = 4;

  // memory model geometry
  localparam int MEM_WORDS  = 64;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);
  // byte offset bits inside one 64-bit word
  localparam int WORD_LSB   = 3;

  // slave response delay, counted from the AR transfer
  localparam int RD_LATENCY = 3;
  localparam int LAT_CNT_W  = $clog2(RD_LATENCY + 1);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [RID_W-1:0]      rid_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;
  typedef logic [LAT_CNT_W-1:0]  lat_cnt_t;

  // fetch reads always carry id 0, memory-stage ids are nonzero
  localparam rid_t IF_ID = 4'd0;

  // addi x0,x0,0
  localparam inst_t NOP_INST = 32'h0000_0013;

  localparam addr_t RESET_PC = 64'h0;

  // one read request, address plus tag
  typedef struct packed {
    addr_t addr;
    rid_t  id;
  } rd_req_t;

  // one read response, word plus the tag it was issued with
  typedef struct packed {
    data_t data;
    rid_t  id;
  } rd_rsp_t;

  // read master states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    AR   = 2'd1,
    R    = 2'd2
  } master_state_e;

endpackage

`default_nettype wire
